// ==== Bender.yml ====
package:
  name: core_datapath

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - common/reg_read_if.sv
      - common/issue_if.sv
      - rtl/instr_decode.sv
      - register_file/register_file.sv
      - rtl/execute_unit.sv
      - rtl/core_datapath.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_core_datapath.sv

// ==== common/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath and register file sizes
`define CORE_DATA_WIDTH      32
`define CORE_NUM_REGS        16
`define CORE_REG_ADDR_WIDTH  4
`define CORE_IMM_WIDTH       16
`define CORE_OPCODE_WIDTH    4

// Instruction field positions
`define CORE_OPCODE_MSB      31
`define CORE_OPCODE_LSB      28
`define CORE_RD_MSB          27
`define CORE_RD_LSB          24
`define CORE_RS1_MSB         23
`define CORE_RS1_LSB         20
`define CORE_RS2_MSB         19
`define CORE_RS2_LSB         16
`define CORE_IMM_MSB         15
`define CORE_IMM_LSB         0

`endif

// ==== common/core_pkg.sv ====
`include "core_consts.svh"

package core_pkg;

  // Register value and register number
  typedef logic [`CORE_DATA_WIDTH-1:0]     data_t;
  typedef logic [`CORE_REG_ADDR_WIDTH-1:0] reg_addr_t;

  // Raw instruction fields
  typedef logic [`CORE_IMM_WIDTH-1:0]      imm_t;
  typedef logic [`CORE_OPCODE_MSB:0]       instr_t;
  typedef logic [`CORE_OPCODE_WIDTH-1:0]   opcode_t;

  // Encoded as the opcode field; codes above ALU_ADDI decode as ALU_NOP
  typedef enum logic [`CORE_OPCODE_WIDTH-1:0] {
    ALU_NOP  = 4'd0,
    ALU_LDI  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SHL  = 4'd7,
    ALU_SHR  = 4'd8,
    ALU_ADDI = 4'd9
  } alu_op_t;

endpackage

// ==== common/issue_if.sv ====
// Decoded instruction on its way to the execute unit
interface issue_if;
  import core_pkg::*;

  logic      valid;
  alu_op_t   op;
  reg_addr_t rd;
  imm_t      imm;
  logic      writes_rd;

  modport producer (
    output valid,
    output op,
    output rd,
    output imm,
    output writes_rd
  );

  modport consumer (
    input  valid,
    input  op,
    input  rd,
    input  imm,
    input  writes_rd
  );

endinterface

// ==== common/reg_read_if.sv ====
// Two read ports of the register file
interface reg_read_if;
  import core_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  data_t     rs1_data;
  data_t     rs2_data;

  // Address side driven by the decoder
  modport decoder (
    output rs1_addr,
    output rs2_addr
  );

  modport regfile (
    input  rs1_addr,
    input  rs2_addr,
    output rs1_data,
    output rs2_data
  );

  // Operand side into the execute unit
  modport reader (
    input  rs1_data,
    input  rs2_data
  );

endinterface

// ==== register_file/register_file.sv ====
`include "core_consts.svh"

module register_file (
  input  logic                clk,
  reg_read_if.regfile         rd_port,
  input  logic                wr_en,
  input  core_pkg::reg_addr_t wr_addr,
  input  core_pkg::data_t     wr_data
);
  import core_pkg::*;

  // Storage is undefined until first written
  data_t regs [`CORE_NUM_REGS];

  data_t rs1_q;
  data_t rs2_q;
  logic  rs1_fwd;
  logic  rs2_fwd;

  // Write-before-read forwarding of the register being written
  assign rs1_fwd = wr_en && (rd_port.rs1_addr == wr_addr);
  assign rs2_fwd = wr_en && (rd_port.rs2_addr == wr_addr);

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Both read ports registered every cycle
  always_ff @(posedge clk)
  begin
    if (rs1_fwd)
    begin
      rs1_q <= wr_data;
    end
    else
    begin
      rs1_q <= regs[rd_port.rs1_addr];
    end

    if (rs2_fwd)
    begin
      rs2_q <= wr_data;
    end
    else
    begin
      rs2_q <= regs[rd_port.rs2_addr];
    end
  end

  assign rd_port.rs1_data = rs1_q;
  assign rd_port.rs2_data = rs2_q;

endmodule

// ==== rtl/core_datapath.sv ====
module core_datapath (
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_valid,
  input  core_pkg::instr_t    instr,
  output logic                result_valid,
  output core_pkg::reg_addr_t result_dest,
  output core_pkg::data_t     result_data
);
  import core_pkg::*;

  // Write-back path from execute to the register file
  logic      wr_en;
  reg_addr_t wr_addr;
  data_t     wr_data;

  reg_read_if rd_bus ();
  issue_if    issue_bus ();

  // Decode and operand address generation
  instr_decode u_instr_decode (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rd_port     (rd_bus.decoder),
    .issue       (issue_bus.producer)
  );

  register_file u_register_file (
    .clk     (clk),
    .rd_port (rd_bus.regfile),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  // ALU stage and result outputs
  execute_unit u_execute_unit (
    .clk          (clk),
    .reset        (reset),
    .rd_port      (rd_bus.reader),
    .issue        (issue_bus.consumer),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .result_valid (result_valid),
    .result_dest  (result_dest),
    .result_data  (result_data)
  );

endmodule

// ==== rtl/execute_unit.sv ====
`include "core_consts.svh"

module execute_unit (
  input  logic                clk,
  input  logic                reset,
  reg_read_if.reader          rd_port,
  issue_if.consumer           issue,
  output logic                wr_en,
  output core_pkg::reg_addr_t wr_addr,
  output core_pkg::data_t     wr_data,
  output logic                result_valid,
  output core_pkg::reg_addr_t result_dest,
  output core_pkg::data_t     result_data
);
  import core_pkg::*;

  localparam int SHAMT_WIDTH = $clog2(`CORE_DATA_WIDTH);

  data_t                  imm_ext;
  logic [SHAMT_WIDTH-1:0] shamt;
  data_t                  alu_result;

  // Sign-extended immediate
  assign imm_ext = {{(`CORE_DATA_WIDTH - `CORE_IMM_WIDTH){issue.imm[`CORE_IMM_WIDTH-1]}},
                    issue.imm};

  // Only the low bits of rs2 count as shift amount
  assign shamt = rd_port.rs2_data[SHAMT_WIDTH-1:0];

  always_comb
  begin
    case (issue.op)
      ALU_LDI:  alu_result = imm_ext;
      ALU_ADD:  alu_result = rd_port.rs1_data + rd_port.rs2_data;
      ALU_SUB:  alu_result = rd_port.rs1_data - rd_port.rs2_data;
      ALU_AND:  alu_result = rd_port.rs1_data & rd_port.rs2_data;
      ALU_OR:   alu_result = rd_port.rs1_data | rd_port.rs2_data;
      ALU_XOR:  alu_result = rd_port.rs1_data ^ rd_port.rs2_data;
      ALU_SHL:  alu_result = rd_port.rs1_data << shamt;
      ALU_SHR:  alu_result = rd_port.rs1_data >> shamt;
      ALU_ADDI: alu_result = rd_port.rs1_data + imm_ext;
      default:  alu_result = '0;
    endcase
  end

  // Write-back lands at the next edge together with the result registers
  assign wr_en   = issue.valid && issue.writes_rd;
  assign wr_addr = issue.rd;
  assign wr_data = alu_result;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= wr_en;
    end
  end

  // Result payload
  always_ff @(posedge clk)
  begin
    result_dest <= wr_addr;
    result_data <= wr_data;
  end

endmodule

// ==== rtl/instr_decode.sv ====
`include "core_consts.svh"

module instr_decode (
  input  logic             clk,
  input  logic             reset,
  input  logic             instr_valid,
  input  core_pkg::instr_t instr,
  reg_read_if.decoder      rd_port,
  issue_if.producer        issue
);
  import core_pkg::*;

  opcode_t   opcode;
  alu_op_t   dec_op;
  reg_addr_t dec_rd;
  imm_t      dec_imm;
  logic      dec_writes_rd;

  // Field extraction
  assign opcode  = instr[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB];
  assign dec_rd  = instr[`CORE_RD_MSB:`CORE_RD_LSB];
  assign dec_imm = instr[`CORE_IMM_MSB:`CORE_IMM_LSB];

  // Read addresses sampled by the register file at the issue edge
  assign rd_port.rs1_addr = instr[`CORE_RS1_MSB:`CORE_RS1_LSB];
  assign rd_port.rs2_addr = instr[`CORE_RS2_MSB:`CORE_RS2_LSB];

  // Opcode values match the enum; anything past ADDI is a NOP
  always_comb
  begin
    if (opcode <= opcode_t'(ALU_ADDI))
    begin
      dec_op = alu_op_t'(opcode);
    end
    else
    begin
      dec_op = ALU_NOP;
    end
  end

  assign dec_writes_rd = (dec_op != ALU_NOP);

  // Issue strobe
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      issue.valid <= 1'b0;
    end
    else
    begin
      issue.valid <= instr_valid;
    end
  end

  // Issue payload that only counts while valid is high
  always_ff @(posedge clk)
  begin
    issue.op        <= dec_op;
    issue.rd        <= dec_rd;
    issue.imm       <= dec_imm;
    issue.writes_rd <= dec_writes_rd;
  end

endmodule

// ==== sim.f ====
+incdir+common
common/core_pkg.sv
common/reg_read_if.sv
common/issue_if.sv
rtl/instr_decode.sv
register_file/register_file.sv
rtl/execute_unit.sv
rtl/core_datapath.sv
testbench/tb_core_datapath.sv

// ==== testbench/tb_core_datapath.sv ====
`include "core_consts.svh"

module tb_core_datapath;
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  localparam int unsigned SEED          = 32'h69cd_59ab;
  localparam int          RESET_CYCLES  = 16;
  localparam int          DRAIN_TIMEOUT = 20;
  // Negedges from the driving edge to a visible result
  localparam int          RESULT_DELAY  = 3;

  logic      clk = 1'b0;
  logic      reset;
  logic      instr_valid;
  instr_t    instr;
  logic      result_valid;
  reg_addr_t result_dest;
  data_t     result_data;

  // Reference model state and expected results in issue order
  data_t     model_regs [`CORE_NUM_REGS];
  reg_addr_t exp_dest_q [$];
  data_t     exp_data_q [$];
  int        exp_due_q [$];
  int        neg_cnt = 0;

  core_datapath dut_i (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result_dest  (result_dest),
    .result_data  (result_data)
  );

  always
  begin
    #4 clk = ~clk;
  end

  function automatic instr_t make_instr(input logic [3:0] opc, input reg_addr_t rd,
                                        input reg_addr_t rs1, input reg_addr_t rs2,
                                        input imm_t imm);
    return {opc, rd, rs1, rs2, imm};
  endfunction

  function automatic reg_addr_t random_reg();
    return reg_addr_t'($urandom % `CORE_NUM_REGS);
  endfunction

  function automatic data_t sext_imm(input imm_t imm);
    return data_t'($signed(imm));
  endfunction

  function automatic bit writes_result(input logic [3:0] opc);
    return (opc >= 4'd1) && (opc <= 4'd9);
  endfunction

  // Shifts use the low five bits of rs2
  function automatic data_t model_result(input logic [3:0] opc, input data_t a,
                                         input data_t b, input imm_t imm);
    data_t res;
    case (opc)
      ALU_LDI:  res = sext_imm(imm);
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_AND:  res = a & b;
      ALU_OR:   res = a | b;
      ALU_XOR:  res = a ^ b;
      ALU_SHL:  res = a << b[4:0];
      ALU_SHR:  res = a >> b[4:0];
      ALU_ADDI: res = a + sext_imm(imm);
      default:  res = '0;
    endcase
    return res;
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s, got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "%s", what);
    end
  endtask

  // Drives one valid instruction and updates the model right away
  task automatic issue_instr(input instr_t word);
    logic [3:0] opc;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    imm_t       imm;
    data_t      value;
    opc = word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB];
    rd  = word[`CORE_RD_MSB:`CORE_RD_LSB];
    rs1 = word[`CORE_RS1_MSB:`CORE_RS1_LSB];
    rs2 = word[`CORE_RS2_MSB:`CORE_RS2_LSB];
    imm = word[`CORE_IMM_MSB:`CORE_IMM_LSB];
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= word;
    if (writes_result(opc))
    begin
      value = model_result(opc, model_regs[rs1], model_regs[rs2], imm);
      model_regs[rd] = value;
      exp_dest_q.push_back(rd);
      exp_data_q.push_back(value);
      exp_due_q.push_back(neg_cnt + RESULT_DELAY);
    end
  endtask

  // Random word on the bus with valid low is ignored
  task automatic idle_cycle();
    @(posedge clk);
    instr_valid <= 1'b0;
    instr       <= instr_t'($urandom);
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while ((exp_due_q.size() != 0) && (waited < DRAIN_TIMEOUT))
    begin
      idle_cycle();
      waited++;
    end
    if (exp_due_q.size() != 0)
    begin
      $display("Timeout at %0t ns: results stopped arriving, %0d still outstanding",
               $time, exp_due_q.size());
      $display("Simulation failed");
      $fatal(1, "results stopped arriving");
    end
  endtask

  task automatic load_all_regs();
    imm_t imm;
    for (int r = 0; r < `CORE_NUM_REGS; r++)
    begin
      imm = imm_t'($urandom);
      // Odd registers get a negative immediate
      imm[`CORE_IMM_WIDTH-1] = r[0];
      issue_instr(make_instr(ALU_LDI, reg_addr_t'(r), random_reg(), random_reg(), imm));
    end
  endtask

  // Wrap-around and shift amounts of 0 and 31
  task automatic run_directed_alu();
    issue_instr(make_instr(ALU_LDI, 4'd1, 4'd0, 4'd0, 16'hffff));
    issue_instr(make_instr(ALU_LDI, 4'd2, 4'd0, 4'd0, 16'h0001));
    issue_instr(make_instr(ALU_LDI, 4'd3, 4'd0, 4'd0, 16'h0000));
    issue_instr(make_instr(ALU_LDI, 4'd4, 4'd0, 4'd0, 16'h001f));
    issue_instr(make_instr(ALU_LDI, 4'd5, 4'd0, 4'd0, 16'h8000));
    issue_instr(make_instr(ALU_ADD, 4'd6, 4'd1, 4'd2, 16'h0000));
    issue_instr(make_instr(ALU_SUB, 4'd7, 4'd3, 4'd2, 16'h0000));
    issue_instr(make_instr(ALU_SHL, 4'd8, 4'd1, 4'd3, 16'h0000));
    issue_instr(make_instr(ALU_SHL, 4'd9, 4'd1, 4'd4, 16'h0000));
    issue_instr(make_instr(ALU_SHR, 4'd10, 4'd1, 4'd4, 16'h0000));
    issue_instr(make_instr(ALU_SHR, 4'd11, 4'd5, 4'd3, 16'h0000));
    issue_instr(make_instr(ALU_ADDI, 4'd12, 4'd1, 4'd0, 16'h0001));
  endtask

  task automatic run_random_alu(input int count);
    logic [3:0] opc;
    for (int i = 0; i < count; i++)
    begin
      opc = 4'(2 + ($urandom % 8));
      issue_instr(make_instr(opc, random_reg(), random_reg(), random_reg(), imm_t'($urandom)));
    end
  endtask

  // Each instruction reads the previous destination on the next cycle
  task automatic run_dependent_chain(input int count);
    logic [3:0] opc;
    reg_addr_t  prev_rd;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    int         sel;
    prev_rd = random_reg();
    for (int i = 0; i < count; i++)
    begin
      opc = 4'(2 + ($urandom % 8));
      rd  = random_reg();
      sel = $urandom % 3;
      rs1 = (sel != 1) ? prev_rd : random_reg();
      rs2 = (sel != 0) ? prev_rd : random_reg();
      issue_instr(make_instr(opc, rd, rs1, rs2, imm_t'($urandom)));
      prev_rd = rd;
    end
  endtask

  task automatic run_nop_checks(input int count);
    logic [3:0] opc;
    int         sel;
    for (int i = 0; i < count; i++)
    begin
      sel = $urandom % 7;
      opc = (sel == 0) ? 4'd0 : 4'(9 + sel);
      issue_instr(make_instr(opc, random_reg(), random_reg(), random_reg(), imm_t'($urandom)));
      if ($urandom % 2)
      begin
        idle_cycle();
      end
    end
    drain_results();
    // Read back every register unchanged
    for (int r = 0; r < `CORE_NUM_REGS; r++)
    begin
      issue_instr(make_instr(ALU_ADDI, reg_addr_t'(r), reg_addr_t'(r), 4'd0, 16'h0000));
    end
  endtask

  task automatic run_gapped_stream(input int count);
    for (int i = 0; i < count; i++)
    begin
      repeat ($urandom % 4) idle_cycle();
      issue_instr(instr_t'($urandom));
    end
  endtask

  // Results compared at the falling edge away from DUT updates
  always @(negedge clk)
  begin
    logic      due_now;
    reg_addr_t dest;
    data_t     data;
    neg_cnt = neg_cnt + 1;
    if (reset === 1'b0)
    begin
      due_now = (exp_due_q.size() != 0) && (exp_due_q[0] == neg_cnt);
      check_equal(result_valid, due_now, "result_valid");
      if (due_now)
      begin
        void'(exp_due_q.pop_front());
        dest = exp_dest_q.pop_front();
        data = exp_data_q.pop_front();
        check_equal(result_dest, dest, "result_dest");
        check_equal(result_data, data, "result_data");
      end
    end
  end

  initial
  begin
    void'($urandom(SEED));
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    // Quiet period with no results expected
    repeat (10) idle_cycle();

    load_all_regs();
    drain_results();
    run_directed_alu();
    run_random_alu(200);
    drain_results();
    run_dependent_chain(100);
    drain_results();
    run_nop_checks(40);
    drain_results();
    run_gapped_stream(200);
    drain_results();
    repeat (4) idle_cycle();

    $display("Simulation passed");
    $finish;
  end

endmodule
